// File: rtl/addr_map.svh
`ifndef ADDR_MAP_SVH
`define ADDR_MAP_SVH

// --------------------
// system bus map
// --------------------
// six regions, none overlapping
// each region spans base up to base + length, end excluded

// debug module, program buffer and rom
localparam logic [AddrWidth-1:0] DebugBase   = 32'h0000_0000;
localparam logic [AddrWidth-1:0] DebugLength = 32'h0000_1000;

// boot rom
localparam logic [AddrWidth-1:0] RomBase     = 32'h0001_0000;
localparam logic [AddrWidth-1:0] RomLength   = 32'h0001_0000;

// core-local interruptor
localparam logic [AddrWidth-1:0] ClintBase   = 32'h0200_0000;
localparam logic [AddrWidth-1:0] ClintLength = 32'h000C_0000;

// debug uart
localparam logic [AddrWidth-1:0] UartBase    = 32'h1000_0000;
localparam logic [AddrWidth-1:0] UartLength  = 32'h0000_1000;

// apb peripherals
localparam logic [AddrWidth-1:0] ApbBase     = 32'h1A10_0000;
localparam logic [AddrWidth-1:0] ApbLength   = 32'h0010_0000;

// l2 scratchpad
localparam logic [AddrWidth-1:0] L2spmBase   = 32'h1C00_0000;
localparam logic [AddrWidth-1:0] L2spmLength = 32'h0008_0000;

`endif

// File: rtl/xbar_pkg.sv
package xbar_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned DataWidth  = 32;
  localparam int unsigned StrbWidth  = DataWidth / 8;

  // requesters: core port and debug master port
  localparam int unsigned NumPorts   = 2;
  localparam int unsigned NumTargets = 6;

  // base and length of every region
  `include "addr_map.svh"

  // --------------------
  // types
  // --------------------
  // index of the mapped region, same order as the rule table
  typedef enum logic [2:0] {
    Debug = 3'd0,
    ROM   = 3'd1,
    UART  = 3'd2,
    CLINT = 3'd3,
    L2SPM = 3'd4,
    APB   = 3'd5
  } target_e;

  // request as issued by a requester
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 we;
    logic [DataWidth-1:0] wdata;
    logic [StrbWidth-1:0] strb;
  } bus_req_t;

  // request after decode, tagged for the downstream side
  typedef struct packed {
    bus_req_t req;
    target_e  target;
    logic     decerr;
    logic     src;
  } routed_req_t;

  // one entry of the address map
  typedef struct packed {
    target_e              idx;
    logic [AddrWidth-1:0] base;
    logic [AddrWidth-1:0] length;
  } rule_t;

  // --------------------
  // rule table
  // --------------------
  // lowest entry wins if two rules ever match
  localparam rule_t AddrRules [NumTargets] = '{
    '{idx: Debug, base: DebugBase, length: DebugLength},
    '{idx: ROM,   base: RomBase,   length: RomLength},
    '{idx: UART,  base: UartBase,  length: UartLength},
    '{idx: CLINT, base: ClintBase, length: ClintLength},
    '{idx: L2SPM, base: L2spmBase, length: L2spmLength},
    '{idx: APB,   base: ApbBase,   length: ApbLength}
  };

endpackage

// File: rtl/port_decode_slice.sv
`timescale 1ns/100ps

module port_decode_slice
  import xbar_pkg::*;
#(
  parameter int unsigned PortIdx = 0
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  // requester side
  input  logic        in_valid_i,
  input  bus_req_t    in_req_i,
  output logic        in_ready_o,
  // towards the arbiter
  output logic        out_valid_o,
  output routed_req_t out_req_o,
  input  logic        out_ready_i
);

  logic [NumTargets-1:0] rule_hit;
  target_e               target;
  logic                  decerr;
  routed_req_t           routed;

  logic                  full_q;
  routed_req_t           slot_q;
  logic                  in_hs;
  logic                  out_hs;

  // --------------------
  // address decode
  // --------------------
  // unsigned difference wraps for addresses below base,
  // so a single compare covers both bounds
  for (genvar i = 0; i < NumTargets; i++) begin : gen_rule
    assign rule_hit[i] = (in_req_i.addr - AddrRules[i].base) < AddrRules[i].length;
  end

  // walk down so the lowest matching rule is the one left standing
  always_comb begin : p_select
    target = Debug;
    decerr = 1'b1;
    for (int i = NumTargets - 1; i >= 0; i--) begin
      if (rule_hit[i]) begin
        target = AddrRules[i].idx;
        decerr = 1'b0;
      end
    end
  end

  // unmapped accesses go on to the responder with decerr set
  assign routed = '{
    req:    in_req_i,
    target: target,
    decerr: decerr,
    src:    1'(PortIdx)
  };

  // --------------------
  // one-entry slot
  // --------------------
  assign in_hs  = in_valid_i & in_ready_o;
  assign out_hs = out_valid_o & out_ready_i;

  // accept when empty or while the current entry leaves
  assign in_ready_o  = ~full_q | out_ready_i;
  assign out_valid_o = full_q;
  assign out_req_o   = slot_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_full
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (in_hs) begin
      full_q <= 1'b1;
    end else if (out_hs) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin : p_slot
    if (in_hs) begin
      slot_q <= routed;
    end
  end

  // --------------------
  // checks
  // --------------------
  // stalled output keeps valid and payload
  a_out_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_req_o)
  ) else $error("slice %0d: output changed while stalled", PortIdx);

  // requester holds its request until accepted
  a_in_hold : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_req_i)
  ) else $error("slice %0d: input request dropped before handshake", PortIdx);

endmodule

// File: rtl/rr_target_arbiter.sv
`timescale 1ns/100ps

module rr_target_arbiter
  import xbar_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // decoded streams from the slices
  input  logic        [NumPorts-1:0] req_valid_i,
  input  routed_req_t [NumPorts-1:0] req_i,
  output logic        [NumPorts-1:0] req_ready_o,
  // merged request channel
  output logic                       out_valid_o,
  output routed_req_t                out_req_o,
  input  logic                       out_ready_i
);

  // index of the port that wins a tie
  logic prio_q;
  logic sel;
  logic out_hs;

  // --------------------
  // selection
  // --------------------
  // priority port if it has something and the other one otherwise
  always_comb begin : p_sel
    sel = prio_q;
    if (!req_valid_i[prio_q]) begin
      sel = ~prio_q;
    end
  end

  assign out_valid_o = |req_valid_i;
  assign out_req_o   = req_i[sel];
  assign out_hs      = out_valid_o & out_ready_i;

  // ready goes back to the forwarded port only
  always_comb begin : p_ready
    req_ready_o      = '0;
    req_ready_o[sel] = out_hs;
  end

  // --------------------
  // priority state
  // --------------------
  // the port left waiting gets the next tie
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_prio
    if (!rst_ni) begin
      prio_q <= 1'b0;
    end else if (out_hs) begin
      prio_q <= ~sel;
    end
  end

  // --------------------
  // checks
  // --------------------
  a_ready_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0(req_ready_o)
  ) else $error("arbiter: more than one port granted");

  // forwarded request comes from a valid port tagged with its own index
  a_out_from_valid : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    out_valid_o |-> req_valid_i[out_req_o.src]
  ) else $error("arbiter: output valid without a matching valid input");

endmodule

// File: rtl/soc_xbar_front.sv
`timescale 1ns/100ps

module soc_xbar_front
  import xbar_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // requesters, port 0 core and port 1 debug master
  input  logic     [NumPorts-1:0] in_valid_i,
  input  bus_req_t [NumPorts-1:0] in_req_i,
  output logic     [NumPorts-1:0] in_ready_o,
  // routed request channel
  output logic                    out_valid_o,
  output routed_req_t             out_req_o,
  input  logic                    out_ready_i
);

  logic        [NumPorts-1:0] dec_valid;
  routed_req_t [NumPorts-1:0] dec_req;
  logic        [NumPorts-1:0] dec_ready;

  // --------------------
  // per-port decode
  // --------------------
  // PortIdx sets the src tag of each stream
  for (genvar i = 0; i < NumPorts; i++) begin : gen_slice
    port_decode_slice #(
      .PortIdx     ( i             )
    ) i_slice (
      .clk_i       ( clk_i         ),
      .rst_ni      ( rst_ni        ),
      .in_valid_i  ( in_valid_i[i] ),
      .in_req_i    ( in_req_i[i]   ),
      .in_ready_o  ( in_ready_o[i] ),
      .out_valid_o ( dec_valid[i]  ),
      .out_req_o   ( dec_req[i]    ),
      .out_ready_i ( dec_ready[i]  )
    );
  end

  // --------------------
  // merge
  // --------------------
  rr_target_arbiter i_arbiter (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .req_valid_i ( dec_valid   ),
    .req_i       ( dec_req     ),
    .req_ready_o ( dec_ready   ),
    .out_valid_o ( out_valid_o ),
    .out_req_o   ( out_req_o   ),
    .out_ready_i ( out_ready_i )
  );

endmodule

// File: sim/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// one request per entry, with the decode result expected for it
typedef struct packed {
  logic                 port;
  logic [AddrWidth-1:0] addr;
  logic                 we;
  logic [DataWidth-1:0] wdata;
  logic [StrbWidth-1:0] strb;
  target_e              target;
  logic                 decerr;
} vec_t;

localparam int NumVecs = 28;

// --------------------
// stimulus table
// --------------------
// columns: port, addr, we, wdata, strb, expected target, expected decerr
localparam vec_t Vecs [NumVecs] = '{
  // base, middle and last byte of every region
  '{1'b0, 32'h0000_0000, 1'b1, 32'hD000_0000, 4'hF, Debug, 1'b0},
  '{1'b1, 32'h0000_0800, 1'b0, 32'hD000_0001, 4'h0, Debug, 1'b0},
  '{1'b0, 32'h0000_0FFF, 1'b1, 32'hD000_0002, 4'h8, Debug, 1'b0},
  '{1'b1, 32'h0001_0000, 1'b0, 32'hD000_0003, 4'h0, ROM,   1'b0},
  '{1'b0, 32'h0001_8000, 1'b0, 32'hD000_0004, 4'h0, ROM,   1'b0},
  '{1'b1, 32'h0001_FFFF, 1'b0, 32'hD000_0005, 4'h0, ROM,   1'b0},
  '{1'b0, 32'h1000_0000, 1'b1, 32'h0000_0041, 4'h1, UART,  1'b0},
  '{1'b1, 32'h1000_0800, 1'b1, 32'h0000_4200, 4'h2, UART,  1'b0},
  '{1'b0, 32'h1000_0FFF, 1'b0, 32'hD000_0008, 4'h0, UART,  1'b0},
  '{1'b1, 32'h0200_0000, 1'b1, 32'h0000_0001, 4'hF, CLINT, 1'b0},
  '{1'b0, 32'h0206_0000, 1'b1, 32'h1234_5678, 4'h3, CLINT, 1'b0},
  '{1'b1, 32'h020B_FFFF, 1'b0, 32'hD000_000B, 4'h0, CLINT, 1'b0},
  '{1'b0, 32'h1C00_0000, 1'b1, 32'hCAFE_F00D, 4'hF, L2SPM, 1'b0},
  '{1'b1, 32'h1C04_0000, 1'b1, 32'hDEAD_BEEF, 4'hC, L2SPM, 1'b0},
  '{1'b0, 32'h1C07_FFFF, 1'b0, 32'hD000_000E, 4'h0, L2SPM, 1'b0},
  '{1'b1, 32'h1A10_0000, 1'b1, 32'h8000_0000, 4'hF, APB,   1'b0},
  '{1'b0, 32'h1A18_0000, 1'b0, 32'hD000_0010, 4'h0, APB,   1'b0},
  '{1'b1, 32'h1A1F_FFFF, 1'b1, 32'h5A5A_A5A5, 4'h5, APB,   1'b0},
  // holes between regions and the top of the space
  '{1'b0, 32'h0000_1000, 1'b0, 32'hE000_0000, 4'h0, Debug, 1'b1},
  '{1'b1, 32'h0000_FFFF, 1'b1, 32'hE000_0001, 4'hF, Debug, 1'b1},
  '{1'b0, 32'h0002_0000, 1'b0, 32'hE000_0002, 4'h0, Debug, 1'b1},
  '{1'b1, 32'h01FF_FFFF, 1'b1, 32'hE000_0003, 4'h1, Debug, 1'b1},
  '{1'b0, 32'h020C_0000, 1'b0, 32'hE000_0004, 4'h0, Debug, 1'b1},
  '{1'b1, 32'h1000_1000, 1'b1, 32'hE000_0005, 4'h6, Debug, 1'b1},
  '{1'b0, 32'h1A0F_FFFF, 1'b0, 32'hE000_0006, 4'h0, Debug, 1'b1},
  '{1'b1, 32'h1A20_0000, 1'b1, 32'hE000_0007, 4'hF, Debug, 1'b1},
  '{1'b0, 32'h1C08_0000, 1'b1, 32'hE000_0008, 4'h9, Debug, 1'b1},
  '{1'b1, 32'hFFFF_FFFC, 1'b0, 32'hE000_0009, 4'h0, Debug, 1'b1}
};

`endif

// File: sim/tb_soc_xbar_front.sv
`timescale 1ns/100ps

module tb_soc_xbar_front
  import xbar_pkg::*;
;

  `include "tb_vectors.svh"

  localparam int MaxWait = 200;

  logic                    clk_i = 1'b0;
  logic                    rst_ni;
  logic     [NumPorts-1:0] in_valid_i;
  bus_req_t [NumPorts-1:0] in_req_i;
  logic     [NumPorts-1:0] in_ready_o;
  logic                    out_valid_o;
  routed_req_t             out_req_o;
  logic                    out_ready_i;

  integer seed = 32'h54a1;
  logic   stall_en = 1'b0;
  logic   timed_out = 1'b0;
  logic   prio = 1'b0;
  int     err_count = 0;
  int     recv_count = 0;
  int     contention_cnt = 0;
  int     cur_idx [NumPorts];
  // table indices accepted on each port and not yet seen at the output
  int     q0 [$];
  int     q1 [$];

  soc_xbar_front i_dut (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .in_valid_i  ( in_valid_i  ),
    .in_req_i    ( in_req_i    ),
    .in_ready_o  ( in_ready_o  ),
    .out_valid_o ( out_valid_o ),
    .out_req_o   ( out_req_o   ),
    .out_ready_i ( out_ready_i )
  );

  always #50 clk_i = ~clk_i;

  // downstream back-pressure, ready about three cycles in four
  always @(posedge clk_i) begin : stall_gen
    if (stall_en) begin
      out_ready_i <= (($random(seed) & 3) != 0);
    end
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  // walks the table and issues this port's entries back to back
  task automatic drive_port(input int p);
    bus_req_t req;
    int       cycles;
    logic     accepted;
    for (int i = 0; i < NumVecs; i++) begin
      if (Vecs[i].port == p[0] && !timed_out) begin
        req.addr  = Vecs[i].addr;
        req.we    = Vecs[i].we;
        req.wdata = Vecs[i].wdata;
        req.strb  = Vecs[i].strb;
        in_valid_i[p] <= 1'b1;
        in_req_i[p]   <= req;
        cur_idx[p]    <= i;
        cycles   = 0;
        accepted = 1'b0;
        while (!accepted && cycles < MaxWait) begin
          @(posedge clk_i);
          cycles++;
          accepted = in_ready_o[p];
        end
        if (!accepted) begin
          $display("ERROR: port %0d request %0d was never accepted", p, i);
          timed_out = 1'b1;
        end
      end
    end
    in_valid_i[p] <= 1'b0;
  endtask

  // --------------------
  // output monitor
  // --------------------
  // drain of a slot is handled before a new fill in the same edge
  always @(posedge clk_i) begin : monitor
    int   idx;
    int   errs_before;
    logic exp_src;
    if (rst_ni) begin
      if (out_valid_o && out_ready_i) begin
        if (q0.size() == 0 && q1.size() == 0) begin
          $display("ERROR: output transfer at %0t with no request pending", $time);
          err_count++;
        end else begin
          // both slots full means a tie, the round-robin model picks
          if (q0.size() > 0 && q1.size() > 0) begin
            exp_src = prio;
            contention_cnt++;
          end else begin
            exp_src = (q0.size() > 0) ? 1'b0 : 1'b1;
          end
          if (exp_src) begin
            idx = q1.pop_front();
          end else begin
            idx = q0.pop_front();
          end
          errs_before = err_count;
          check("out_req_o.src",       out_req_o.src,       Vecs[idx].port);
          check("out_req_o.req.addr",  out_req_o.req.addr,  Vecs[idx].addr);
          check("out_req_o.req.we",    out_req_o.req.we,    Vecs[idx].we);
          check("out_req_o.req.wdata", out_req_o.req.wdata, Vecs[idx].wdata);
          check("out_req_o.req.strb",  out_req_o.req.strb,  Vecs[idx].strb);
          check("out_req_o.target",    out_req_o.target,    Vecs[idx].target);
          check("out_req_o.decerr",    out_req_o.decerr,    Vecs[idx].decerr);
          prio = ~exp_src;
          recv_count++;
          $display("test %2d: port %0d addr %h target %0d decerr %b %s", idx,
                   Vecs[idx].port, Vecs[idx].addr, Vecs[idx].target, Vecs[idx].decerr,
                   (err_count == errs_before) ? "ok" : "mismatch");
        end
      end
      if (in_valid_i[0] && in_ready_o[0]) begin
        q0.push_back(cur_idx[0]);
      end
      if (in_valid_i[1] && in_ready_o[1]) begin
        q1.push_back(cur_idx[1]);
      end
    end
  end

  // --------------------
  // main sequence
  // --------------------
  initial begin : main
    int cycles;
    int errs_before;
    in_valid_i  = '0;
    in_req_i    = '0;
    out_ready_i = 1'b0;
    rst_ni      = 1'b0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    @(posedge clk_i);
    errs_before = err_count;
    check("out_valid_o", out_valid_o, 1'b0);
    check("in_ready_o",  in_ready_o,  2'b11);
    $display("test reset: idle outputs %s", (err_count == errs_before) ? "ok" : "mismatch");

    stall_en <= 1'b1;
    fork
      drive_port(0);
      drive_port(1);
    join

    cycles = 0;
    while (recv_count < NumVecs && cycles < MaxWait) begin
      @(posedge clk_i);
      cycles++;
    end
    if (recv_count < NumVecs) begin
      $display("ERROR: only %0d of %0d requests came out before the timeout",
               recv_count, NumVecs);
      timed_out = 1'b1;
    end
    // a few idle cycles so a duplicate transfer would still be caught
    repeat (8) @(posedge clk_i);

    check("received count", recv_count, NumVecs);
    check("tie transfers seen", (contention_cnt > 0), 1'b1);
    $display("summary: %0d of %0d requests out, %0d ties, %0d errors",
             recv_count, NumVecs, contention_cnt, err_count);
    if (err_count == 0 && !timed_out) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+rtl
+incdir+sim
rtl/xbar_pkg.sv
rtl/port_decode_slice.sv
rtl/rr_target_arbiter.sv
rtl/soc_xbar_front.sv
sim/tb_soc_xbar_front.sv
